// ==== src.f ====
src/hazardPkg.sv
src/instrClassifier.sv
src/stallControl.sv
src/execTrack.sv
src/memTrack.sv
src/wbTrack.sv
src/operandForward.sv
src/hazardUnit.sv
verification/hazardUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the hazard unit testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module hazardUnitTb -o hazardUnitSim
./obj_dir/hazardUnitSim > sim.log
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi

// ==== verification/hazardUnitTb.sv ====
`timescale 1ns/1ps

module hazardUnitTb;

    localparam int resetCycles   = 16;
    localparam int rowCount      = 40;
    localparam int testCount     = 7;
    localparam int timeoutCycles = resetCycles + rowCount + 20;

    typedef struct packed {
        logic [2:0]         testId;
        hazardPkg::wordT    instr;
        hazardPkg::wordT    pc;
        hazardPkg::wordT    aluOut;
        hazardPkg::wordT    memData;
        logic               stall;
        hazardPkg::fwdPairT fwdD;
        hazardPkg::fwdPairT fwdE;
        hazardPkg::wbPortT  wb;
    } rowT;

    logic               clk = 1'b0;
    logic               rstN;
    hazardPkg::wordT    instrD;
    hazardPkg::wordT    pcD;
    hazardPkg::wordT    aluOutM;
    hazardPkg::wordT    memDataW;
    logic               stall;
    hazardPkg::fwdPairT fwdD;
    hazardPkg::fwdPairT fwdE;
    hazardPkg::wbPortT  wbWrite;

    rowT             tbl[rowCount];
    string           testNames[8];
    int              testErrs[8];
    int              nRows;
    int              errCount;
    int              checkCount;
    int              cycleCount;
    logic [31:0]     lfsrState = 32'd18;
    hazardPkg::wordT pcNext;

    hazardUnit uut (.clk(clk), .rstN(rstN), .instrD(instrD), .pcD(pcD), .aluOutM(aluOutM),
                    .memDataW(memDataW), .stall(stall), .fwdD(fwdD), .fwdE(fwdE),
                    .wbWrite(wbWrite));

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1); // galois, right shift
    endfunction

    task automatic drawWord(output hazardPkg::wordT w);
        int b;
        w = '0;
        for (b = 0; b < 32; b++) begin
            w = {lfsrState[0], w[31:1]}; // one step per bit
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    function automatic hazardPkg::wordT encodeR(input logic [5:0] fn,
                                                input hazardPkg::regAddrT rs,
                                                input hazardPkg::regAddrT rt,
                                                input hazardPkg::regAddrT rd);
        return {hazardPkg::opSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic hazardPkg::wordT encodeI(input logic [5:0] op,
                                                input hazardPkg::regAddrT rs,
                                                input hazardPkg::regAddrT rt,
                                                input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic hazardPkg::wordT encodeJ(input logic [5:0] op,
                                                input logic [25:0] target);
        return {op, target};
    endfunction

    task automatic addRow(input logic [2:0] testId, input hazardPkg::wordT instr);
        rowT             r;
        hazardPkg::wordT a;
        hazardPkg::wordT m;
        drawWord(a);
        drawWord(m);
        r         = '0;
        r.testId  = testId;
        r.instr   = instr;
        r.pc      = pcNext;
        r.aluOut  = a;
        r.memData = m;
        tbl[nRows] = r;
        nRows++;
        pcNext = pcNext + 32'd4;
    endtask

    // decode held while stalled, only the datapath values move on
    task automatic repeatRow();
        rowT             r;
        hazardPkg::wordT a;
        hazardPkg::wordT m;
        drawWord(a);
        drawWord(m);
        r         = tbl[nRows - 1];
        r.aluOut  = a;
        r.memData = m;
        tbl[nRows] = r;
        nRows++;
    endtask

    task automatic expectStall(input int i);
        tbl[i].stall = 1'b1;
    endtask

    task automatic expectFwdD(input int i, input logic onRt, input hazardPkg::wordT d);
        if (onRt) begin
            tbl[i].fwdD.rt = '{hit: 1'b1, data: d};
        end else begin
            tbl[i].fwdD.rs = '{hit: 1'b1, data: d};
        end
    endtask

    task automatic expectFwdE(input int i, input logic onRt, input hazardPkg::wordT d);
        if (onRt) begin
            tbl[i].fwdE.rt = '{hit: 1'b1, data: d};
        end else begin
            tbl[i].fwdE.rs = '{hit: 1'b1, data: d};
        end
    endtask

    task automatic expectWb(input int i, input hazardPkg::regAddrT a, input hazardPkg::wordT d);
        tbl[i].wb = '{en: 1'b1, addr: a, data: d};
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus and expected values
    ////////////////////////////////////////////////////////////
    task automatic buildTable();
        int t;
        nRows  = 0;
        pcNext = 32'h0040_0000;
        for (t = 0; t < 8; t++) testErrs[t] = 0;
        testNames[0] = "reset and idle";
        testNames[1] = "alu to alu";
        testNames[2] = "load to alu";
        testNames[3] = "load to branch";
        testNames[4] = "jal to jr";
        testNames[5] = "jalr to jr";
        testNames[6] = "no write";
        testNames[7] = "";

        repeat (3) addRow(3'd0, 32'h0);                                         // rows 0-2
        addRow(3'd1, encodeR(hazardPkg::fnAdd, 5'd1, 5'd2, 5'd3));              // 3 add $3
        addRow(3'd1, encodeR(hazardPkg::fnSub, 5'd5, 5'd3, 5'd4));              // 4 sub $4
        repeat (3) addRow(3'd1, 32'h0);
        addRow(3'd2, encodeI(hazardPkg::opLw, 5'd1, 5'd6, 16'h0000));           // 8 lw $6
        addRow(3'd2, encodeR(hazardPkg::fnAdd, 5'd6, 5'd2, 5'd7));              // 9 add $7
        repeatRow();
        repeat (3) addRow(3'd2, 32'h0);
        addRow(3'd3, encodeI(hazardPkg::opLw, 5'd1, 5'd8, 16'h0004));           // 14 lw $8
        addRow(3'd3, encodeI(hazardPkg::opBeq, 5'd9, 5'd8, 16'h0010));          // 15 beq
        repeatRow();
        repeatRow();
        repeat (2) addRow(3'd3, 32'h0);
        addRow(3'd4, encodeJ(hazardPkg::opJal, 26'h010_0040));                 // 20 jal
        addRow(3'd4, encodeR(hazardPkg::fnJr, 5'd31, 5'd0, 5'd0));              // 21 jr $31
        repeat (3) addRow(3'd4, 32'h0);
        addRow(3'd5, encodeR(hazardPkg::fnJalr, 5'd11, 5'd0, 5'd10));           // 25 jalr $10
        addRow(3'd5, encodeR(hazardPkg::fnJr, 5'd10, 5'd0, 5'd0));              // 26 jr $10
        repeat (2) addRow(3'd5, 32'h0);
        addRow(3'd6, encodeI(hazardPkg::opSw, 5'd13, 5'd12, 16'h0000));         // 29 sw
        addRow(3'd6, encodeI(hazardPkg::opBeq, 5'd12, 5'd13, 16'h0008));        // 30 beq
        addRow(3'd6, encodeJ(hazardPkg::opJ, 26'h010_0000));                   // 31 j
        addRow(3'd6, 32'h4200_0018);                                            // 32 eret
        addRow(3'd6, 32'h400E_6000);                                            // 33 mfc0 $14
        addRow(3'd6, 32'h408E_6000);                                            // 34 mtc0 $14
        addRow(3'd6, encodeR(hazardPkg::fnAdd, 5'd1, 5'd2, 5'd0));              // 35 add $0
        addRow(3'd6, encodeR(hazardPkg::fnAdd, 5'd0, 5'd14, 5'd15));            // 36 add $15
        repeat (3) addRow(3'd6, 32'h0);

        // results counted from the slot each instruction sits in
        expectFwdE(5, 1'b1, tbl[5].aluOut);
        expectWb(6, 5'd3, tbl[5].aluOut);
        expectWb(7, 5'd4, tbl[6].aluOut);
        expectStall(9);
        expectFwdE(11, 1'b0, tbl[11].memData);
        expectWb(11, 5'd6, tbl[11].memData);
        expectWb(13, 5'd7, tbl[12].aluOut);
        expectStall(15);
        expectStall(16);
        expectFwdD(17, 1'b1, tbl[17].memData);
        expectWb(17, 5'd8, tbl[17].memData);
        expectFwdD(21, 1'b0, tbl[20].pc + 32'd8);
        expectFwdE(22, 1'b0, tbl[20].pc + 32'd8);
        expectWb(23, 5'd31, tbl[20].pc + 32'd8);
        expectFwdD(26, 1'b0, tbl[25].pc + 32'd8);
        expectFwdE(27, 1'b0, tbl[25].pc + 32'd8);
        expectWb(28, 5'd10, tbl[25].pc + 32'd8);
        expectWb(39, 5'd15, tbl[38].aluOut);
    endtask

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////
    task automatic flagValue(input string name, input string where, input logic [2:0] testId,
                             input logic [65:0] got, input logic [65:0] want);
        $display("CHECK FAILED %s at %s: got 0x%h, expected 0x%h", name, where, got, want);
        errCount++;
        testErrs[testId]++;
    endtask

    task automatic checkQuiet(input int c);
        string    where;
        logic [3:0] hits;
        where = $sformatf("reset cycle %0d", c);
        hits  = {fwdD.rs.hit, fwdD.rt.hit, fwdE.rs.hit, fwdE.rt.hit};
        checkCount += 3;
        assert (stall === 1'b0) else flagValue("stall", where, 3'd0, {65'd0, stall}, 66'd0);
        assert (hits === 4'd0) else flagValue("hits", where, 3'd0, {62'd0, hits}, 66'd0);
        assert (wbWrite.en === 1'b0)
            else flagValue("wbWrite.en", where, 3'd0, {65'd0, wbWrite.en}, 66'd0);
    endtask

    task automatic checkRow(input int i);
        rowT   r;
        string where;
        r     = tbl[i];
        where = $sformatf("row %0d", i);
        checkCount += 4;
        assert (stall === r.stall)
            else flagValue("stall", where, r.testId, {65'd0, stall}, {65'd0, r.stall});
        assert (fwdD === r.fwdD) else flagValue("fwdD", where, r.testId, fwdD, r.fwdD);
        assert (fwdE === r.fwdE) else flagValue("fwdE", where, r.testId, fwdE, r.fwdE);
        assert (wbWrite.en === r.wb.en)
            else flagValue("wbWrite.en", where, r.testId, {65'd0, wbWrite.en}, {65'd0, r.wb.en});
        if (r.wb.en) begin
            checkCount++;
            assert (wbWrite === r.wb)
                else flagValue("wbWrite", where, r.testId, {28'd0, wbWrite}, {28'd0, r.wb});
        end
    endtask

    task automatic reportTest(input logic [2:0] t);
        $display("test %0d %s: %s", t, testNames[t], (testErrs[t] == 0) ? "ok" : "errors");
    endtask

    initial begin
        int c;
        int i;
        rstN     = 1'b0;
        instrD   = '0;
        pcD      = '0;
        aluOutM  = '0;
        memDataW = '0;
        errCount   = 0;
        checkCount = 0;
        buildTable();

        for (c = 0; c < resetCycles; c++) begin
            @(posedge clk);
            #2;
            checkQuiet(c);
        end
        @(negedge clk);
        rstN = 1'b1;

        for (i = 0; i < rowCount; i++) begin
            instrD   = tbl[i].instr;
            pcD      = tbl[i].pc;
            aluOutM  = tbl[i].aluOut;
            memDataW = tbl[i].memData;
            #2; // combinational outputs settled well before the rising edge
            checkRow(i);
            if (i == rowCount - 1 || tbl[i + 1].testId != tbl[i].testId) begin
                reportTest(tbl[i].testId);
            end
            @(negedge clk);
        end

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: run did not finish within %0d cycles", timeoutCycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== src/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
    input  logic               clk,
    input  logic               rstN,
    input  hazardPkg::wordT    instrD,
    input  hazardPkg::wordT    pcD,
    input  hazardPkg::wordT    aluOutM,
    input  hazardPkg::wordT    memDataW,
    output logic               stall,
    output hazardPkg::fwdPairT fwdD,
    output hazardPkg::fwdPairT fwdE,
    output hazardPkg::wbPortT  wbWrite
);

    hazardPkg::needT   needD;
    hazardPkg::needT   needE;
    hazardPkg::hazRecT recD;
    hazardPkg::hazRecT recE;
    hazardPkg::hazRecT recM;
    hazardPkg::hazRecT recW;

    ////////////////////////////////////////////////////////////
    // decode side
    ////////////////////////////////////////////////////////////
    instrClassifier classify (.instrD(instrD), .pcD(pcD), .needD(needD), .recD(recD));

    stallControl stallCtl (.needD(needD), .recE(recE), .recM(recM), .stall(stall));

    ////////////////////////////////////////////////////////////
    // record pipeline E -> M -> W
    ////////////////////////////////////////////////////////////
    execTrack execSlot (.clk(clk), .rstN(rstN), .stall(stall), .recD(recD),
                        .needD(needD), .recE(recE), .needE(needE));

    memTrack memSlot (.clk(clk), .rstN(rstN), .recE(recE), .aluOutM(aluOutM),
                      .recM(recM));

    wbTrack wbSlot (.clk(clk), .rstN(rstN), .recM(recM), .memDataW(memDataW),
                    .recW(recW), .wbWrite(wbWrite));

    operandForward forward (.needD(needD), .needE(needE), .recE(recE), .recM(recM),
                            .recW(recW), .fwdD(fwdD), .fwdE(fwdE));

endmodule

// ==== src/operandForward.sv ====
`timescale 1ns/1ps

module operandForward (
    input  hazardPkg::needT    needD,
    input  hazardPkg::needT    needE,
    input  hazardPkg::hazRecT  recE,
    input  hazardPkg::hazRecT  recM,
    input  hazardPkg::hazRecT  recW,
    output hazardPkg::fwdPairT fwdD,
    output hazardPkg::fwdPairT fwdE
);

    // youngest matching record decides, ready or not
    function automatic hazardPkg::fwdT search(
        input hazardPkg::regAddrT r,
        input hazardPkg::hazRecT  young,
        input hazardPkg::hazRecT  mid,
        input hazardPkg::hazRecT  old
    );
        hazardPkg::hazRecT src;
        logic              found;
        hazardPkg::fwdT    f;
        found = 1'b1;
        src   = old;
        if (young.dest == r) src = young;
        else if (mid.dest == r) src = mid;
        else if (old.dest != r) found = 1'b0;
        f.hit  = found && (r != '0) && (src.tnew == '0); // $0 never hits
        f.data = f.hit ? src.value : '0;
        return f;
    endfunction

    assign fwdD.rs = search(needD.rs, recE, recM, recW);
    assign fwdD.rt = search(needD.rt, recE, recM, recW);

    // execute has nothing younger than M
    assign fwdE.rs = search(needE.rs, hazardPkg::bubbleRec, recM, recW);
    assign fwdE.rt = search(needE.rt, hazardPkg::bubbleRec, recM, recW);

endmodule

// ==== src/wbTrack.sv ====
`timescale 1ns/1ps

module wbTrack (
    input  logic              clk,
    input  logic              rstN,
    input  hazardPkg::hazRecT recM,
    input  hazardPkg::wordT   memDataW,
    output hazardPkg::hazRecT recW,
    output hazardPkg::wbPortT wbWrite
);

    hazardPkg::hazRecT recQ;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            recQ <= hazardPkg::bubbleRec;
        end else begin
            recQ <= recM; // already holds aluOutM for alu kinds
        end
    end

    always_comb begin
        recW      = recQ;
        recW.tnew = '0; // everything is ready in W
        if (recQ.kind == hazardPkg::kindLoad) begin
            recW.value = memDataW;
        end
    end

    ////////////////////////////////////////////////////////////
    // register file write port
    ////////////////////////////////////////////////////////////
    assign wbWrite.en   = (recW.dest != '0);
    assign wbWrite.addr = recW.dest;
    assign wbWrite.data = recW.value;

endmodule

// ==== src/memTrack.sv ====
`timescale 1ns/1ps

module memTrack (
    input  logic              clk,
    input  logic              rstN,
    input  hazardPkg::hazRecT recE,
    input  hazardPkg::wordT   aluOutM,
    output hazardPkg::hazRecT recM
);

    hazardPkg::hazRecT recQ;
    hazardPkg::timeT   agedTnew;

    assign agedTnew = (recE.tnew == '0) ? '0 : recE.tnew - 2'd1; // floor at 0

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            recQ <= hazardPkg::bubbleRec;
        end else begin
            recQ      <= recE;
            recQ.tnew <= agedTnew;
        end
    end

    always_comb begin
        recM = recQ;
        if (recQ.kind == hazardPkg::kindAlu) begin
            recM.value = aluOutM; // alu result now available
            recM.tnew  = '0;
        end
    end

endmodule

// ==== src/execTrack.sv ====
`timescale 1ns/1ps

module execTrack (
    input  logic              clk,
    input  logic              rstN,
    input  logic              stall,
    input  hazardPkg::hazRecT recD,
    input  hazardPkg::needT   needD,
    output hazardPkg::hazRecT recE,
    output hazardPkg::needT   needE
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            recE  <= hazardPkg::bubbleRec;
            needE <= hazardPkg::noNeed;
        end else if (stall) begin
            recE  <= hazardPkg::bubbleRec; // decode holds, E gets a bubble
            needE <= hazardPkg::noNeed;
        end else begin
            recE  <= recD;
            needE <= needD;
        end
    end

endmodule

// ==== src/stallControl.sv ====
`timescale 1ns/1ps

module stallControl (
    input  hazardPkg::needT   needD,
    input  hazardPkg::hazRecT recE,
    input  hazardPkg::hazRecT recM,
    output logic              stall
);

    // result not ready by the time decode needs it
    function automatic logic tooLate(
        input hazardPkg::regAddrT r,
        input hazardPkg::hazRecT  rec,
        input hazardPkg::timeT    tuse
    );
        return (r != '0) && (r == rec.dest) && (rec.tnew > tuse);
    endfunction

    logic rsLate;
    logic rtLate;

    assign rsLate = tooLate(needD.rs, recE, needD.tuse) ||
                    tooLate(needD.rs, recM, needD.tuse);
    assign rtLate = tooLate(needD.rt, recE, needD.tuse) ||
                    tooLate(needD.rt, recM, needD.tuse);

    assign stall = rsLate || rtLate;

endmodule

// ==== src/instrClassifier.sv ====
`timescale 1ns/1ps

module instrClassifier (
    input  hazardPkg::wordT   instrD,
    input  hazardPkg::wordT   pcD,
    output hazardPkg::needT   needD,
    output hazardPkg::hazRecT recD
);

    logic [5:0]         opcode;
    logic [5:0]         funct;
    hazardPkg::regAddrT rsF;
    hazardPkg::regAddrT rtF;
    hazardPkg::regAddrT rdF;
    hazardPkg::wordT    linkVal;

    assign opcode  = instrD[31:26];
    assign funct   = instrD[5:0];
    assign rsF     = instrD[25:21];
    assign rtF     = instrD[20:16];
    assign rdF     = instrD[15:11];
    assign linkVal = pcD + hazardPkg::linkOffset;

    always_comb begin
        needD = hazardPkg::noNeed; // nop unless matched below
        recD  = hazardPkg::bubbleRec;
        case (opcode)
            hazardPkg::opSpecial: begin
                case (funct)
                    hazardPkg::fnSll, hazardPkg::fnSrl, hazardPkg::fnSra: begin
                        needD.rt   = rtF; // shamt form reads rt only
                        needD.tuse = 2'd1;
                        recD.dest  = rdF;
                        recD.tnew  = hazardPkg::tnewAlu;
                        recD.kind  = hazardPkg::kindAlu;
                    end
                    hazardPkg::fnSllv, hazardPkg::fnSrlv, hazardPkg::fnSrav,
                    hazardPkg::fnAdd, hazardPkg::fnAddu, hazardPkg::fnSub,
                    hazardPkg::fnSubu, hazardPkg::fnAnd, hazardPkg::fnOr,
                    hazardPkg::fnXor, hazardPkg::fnNor, hazardPkg::fnSlt,
                    hazardPkg::fnSltu: begin
                        needD.rs   = rsF;
                        needD.rt   = rtF;
                        needD.tuse = 2'd1;
                        recD.dest  = rdF;
                        recD.tnew  = hazardPkg::tnewAlu;
                        recD.kind  = hazardPkg::kindAlu;
                    end
                    hazardPkg::fnJr: begin
                        needD.rs   = rsF;
                        needD.tuse = 2'd0; // target read in decode
                    end
                    hazardPkg::fnJalr: begin
                        needD.rs   = rsF;
                        needD.tuse = 2'd0;
                        recD.dest  = rdF;
                        recD.kind  = hazardPkg::kindLink;
                        recD.value = linkVal;
                    end
                    default: ;
                endcase
            end
            hazardPkg::opRegImm: begin
                if (rtF == hazardPkg::rtBltz || rtF == hazardPkg::rtBgez) begin
                    needD.rs   = rsF;
                    needD.tuse = 2'd0;
                end
            end
            hazardPkg::opBeq, hazardPkg::opBne: begin
                needD.rs   = rsF;
                needD.rt   = rtF;
                needD.tuse = 2'd0; // compare in decode
            end
            hazardPkg::opBlez, hazardPkg::opBgtz: begin
                needD.rs   = rsF;
                needD.tuse = 2'd0;
            end
            hazardPkg::opJ: ;
            hazardPkg::opJal: begin
                recD.dest  = hazardPkg::linkReg;
                recD.kind  = hazardPkg::kindLink;
                recD.value = linkVal;
            end
            hazardPkg::opAddi, hazardPkg::opAddiu, hazardPkg::opSlti,
            hazardPkg::opSltiu, hazardPkg::opAndi, hazardPkg::opOri,
            hazardPkg::opXori: begin
                needD.rs   = rsF;
                needD.tuse = 2'd1;
                recD.dest  = rtF;
                recD.tnew  = hazardPkg::tnewAlu;
                recD.kind  = hazardPkg::kindAlu;
            end
            hazardPkg::opLui: begin
                recD.dest = rtF; // no source register
                recD.tnew = hazardPkg::tnewAlu;
                recD.kind = hazardPkg::kindAlu;
            end
            hazardPkg::opLb, hazardPkg::opLh, hazardPkg::opLw,
            hazardPkg::opLbu, hazardPkg::opLhu: begin
                needD.rs   = rsF;
                needD.tuse = 2'd1;
                recD.dest  = rtF;
                recD.tnew  = hazardPkg::tnewLoad;
                recD.kind  = hazardPkg::kindLoad;
            end
            hazardPkg::opSb, hazardPkg::opSh, hazardPkg::opSw: begin
                needD.rs   = rsF; // base only
                needD.tuse = 2'd1;
            end
            default: ;
        endcase
    end

endmodule

// ==== src/hazardPkg.sv ====
package hazardPkg;

    ////////////////////////////////////////////////////////////
    // widths and base types
    ////////////////////////////////////////////////////////////
    localparam int wordW = 32;
    localparam int regW  = 5;
    localparam int timeW = 2;

    typedef logic [wordW-1:0] wordT;
    typedef logic [regW-1:0]  regAddrT;
    typedef logic [timeW-1:0] timeT;

    ////////////////////////////////////////////////////////////
    // instruction fields
    ////////////////////////////////////////////////////////////
    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opRegImm  = 6'b000001;
    localparam logic [5:0] opJ       = 6'b000010;
    localparam logic [5:0] opJal     = 6'b000011;
    localparam logic [5:0] opBeq     = 6'b000100;
    localparam logic [5:0] opBne     = 6'b000101;
    localparam logic [5:0] opBlez    = 6'b000110;
    localparam logic [5:0] opBgtz    = 6'b000111;
    localparam logic [5:0] opAddi    = 6'b001000;
    localparam logic [5:0] opAddiu   = 6'b001001;
    localparam logic [5:0] opSlti    = 6'b001010;
    localparam logic [5:0] opSltiu   = 6'b001011;
    localparam logic [5:0] opAndi    = 6'b001100;
    localparam logic [5:0] opOri     = 6'b001101;
    localparam logic [5:0] opXori    = 6'b001110;
    localparam logic [5:0] opLui     = 6'b001111;
    localparam logic [5:0] opLb      = 6'b100000;
    localparam logic [5:0] opLh      = 6'b100001;
    localparam logic [5:0] opLw      = 6'b100011;
    localparam logic [5:0] opLbu     = 6'b100100;
    localparam logic [5:0] opLhu     = 6'b100101;
    localparam logic [5:0] opSb      = 6'b101000;
    localparam logic [5:0] opSh      = 6'b101001;
    localparam logic [5:0] opSw      = 6'b101011;

    localparam logic [5:0] fnSll  = 6'b000000;
    localparam logic [5:0] fnSrl  = 6'b000010;
    localparam logic [5:0] fnSra  = 6'b000011;
    localparam logic [5:0] fnSllv = 6'b000100;
    localparam logic [5:0] fnSrlv = 6'b000110;
    localparam logic [5:0] fnSrav = 6'b000111;
    localparam logic [5:0] fnJr   = 6'b001000;
    localparam logic [5:0] fnJalr = 6'b001001;
    localparam logic [5:0] fnAdd  = 6'b100000;
    localparam logic [5:0] fnAddu = 6'b100001;
    localparam logic [5:0] fnSub  = 6'b100010;
    localparam logic [5:0] fnSubu = 6'b100011;
    localparam logic [5:0] fnAnd  = 6'b100100;
    localparam logic [5:0] fnOr   = 6'b100101;
    localparam logic [5:0] fnXor  = 6'b100110;
    localparam logic [5:0] fnNor  = 6'b100111;
    localparam logic [5:0] fnSlt  = 6'b101010;
    localparam logic [5:0] fnSltu = 6'b101011;

    localparam regAddrT rtBltz = 5'b00000; // regimm selects in the rt field
    localparam regAddrT rtBgez = 5'b00001;

    localparam regAddrT linkReg    = 5'd31;
    localparam wordT    linkOffset = 32'd8;

    ////////////////////////////////////////////////////////////
    // timing and records
    ////////////////////////////////////////////////////////////
    localparam timeT tuseNever = 2'd3;
    localparam timeT tnewAlu   = 2'd1;
    localparam timeT tnewLoad  = 2'd2;

    typedef enum logic [1:0] {
        kindNone = 2'd0,
        kindLink = 2'd1,
        kindAlu  = 2'd2,
        kindLoad = 2'd3
    } resultKindE;

    typedef struct packed {
        regAddrT    dest;  // 0 means nothing to write
        timeT       tnew;
        resultKindE kind;
        wordT       value;
    } hazRecT;

    typedef struct packed {
        regAddrT rs;
        regAddrT rt;
        timeT    tuse;
    } needT;

    typedef struct packed {
        logic hit;
        wordT data;
    } fwdT;

    typedef struct packed {
        fwdT rs;
        fwdT rt;
    } fwdPairT;

    typedef struct packed {
        logic    en;
        regAddrT addr;
        wordT    data;
    } wbPortT;

    localparam hazRecT bubbleRec = '{dest: '0, tnew: '0, kind: kindNone, value: '0};
    localparam needT   noNeed    = '{rs: '0, rt: '0, tuse: tuseNever};

endpackage
